// File: filelist.f
common/dbg_pkg.sv
logic/strap_sampler.sv
pinmux/dps_pinmux.sv
logic/jtag_idcode_tap.sv
spi_device/spi_cmd_rx.sv
sim_sram/sim_sram.sv
logic/dbg_chip_top.sv
sim/dbg_chip_assertions.sv
sim/tb_dbg_chip.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_dbg_chip -o tb_dbg_chip
	./obj_dir/tb_dbg_chip | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: sim/tb_dbg_chip.sv
`timescale 1ns/1ps
// Table driven testbench, SCK and TCK run at 16 clk_i cycles per period
// First mismatch ends the run, a cycle limit guards against hangs
module tb_dbg_chip;
  import dbg_pkg::*;

  localparam logic [3:0] K_RST = 0, K_JID = 1, K_JBYP = 2, K_SPI = 3, K_SPICHK = 4;
  localparam logic [3:0] K_STAT = 5, K_PINS = 6, K_STRAP = 7, K_SHORT = 8;

  typedef struct packed {
    logic [3:0]  kind;
    logic [7:0]  op;
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
  } entry_t;

  logic         clk;
  logic         arst_n;
  logic [7:0]   pads;  // 0 TCK/SCK, 1 TDI/SDI, 3 TMS/CSB, 4 TRST_N, 5 SRST_N, 6, 7 straps
  logic         dps;
  strap_t       strap;
  test_status_e status;
  entry_t       table_q[$];
  logic [31:0]  words[4];
  integer       seed;
  int unsigned  cycles;
  int unsigned  limit;

  dbg_chip_top i_dut (
    .clk_i(clk), .arst_n_i(arst_n), .io_dps_i(pads),
    .dps_o(dps), .strap_o(strap), .test_status_o(status)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic stop_on_mismatch(input string what);
    $display("CHECK FAILED at %0t ns: %s", $time, what);
    $display("TESTS FAILED");
    $fatal(1, "mismatch");
  endtask

  task automatic add_entry(input logic [3:0] kind, input logic [7:0] op,
                           input logic [15:0] addr, input logic [31:0] data,
                           input logic [31:0] exp);
    table_q.push_back('{kind, op, addr, data, exp});
  endtask

  task automatic apply_reset(input logic [1:0] straps);  // {jtag_spi_n, bootstrap}
    @(posedge clk);
    arst_n  <= 1'b0;
    pads[6] <= straps[1];
    pads[7] <= straps[0];
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    repeat (10) @(posedge clk);
  endtask

  // One TCK period, TDO sampled just before the rising edge
  task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
    @(posedge clk);
    pads[3] <= tms;
    pads[1] <= tdi;
    repeat (7) @(posedge clk);
    @(negedge clk) tdo = dps;
    @(posedge clk) pads[0] <= 1'b1;
    repeat (7) @(posedge clk);
    @(posedge clk) pads[0] <= 1'b0;
  endtask

  task automatic jtag_read_idcode(output logic [31:0] id);
    logic b;
    repeat (5) tck_cycle(1'b1, 1'b0, b);  // Test-Logic-Reset
    tck_cycle(1'b0, 1'b0, b);
    tck_cycle(1'b1, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);  // Now in Shift-DR
    for (int i = 0; i < 32; i++) begin
      tck_cycle(i == 31, 1'b0, b);
      id[i] = b;
    end
    tck_cycle(1'b1, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);
  endtask

  task automatic jtag_bypass(input logic [7:0] pat, output logic [7:0] got);
    logic b;
    tck_cycle(1'b1, 1'b0, b);
    tck_cycle(1'b1, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);  // Shift-IR
    for (int i = 0; i < IR_LEN; i++) tck_cycle(i == IR_LEN - 1, 1'b1, b);
    tck_cycle(1'b1, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);  // Idle with all-ones IR
    tck_cycle(1'b1, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);  // Shift-DR
    for (int i = 0; i < 8; i++) begin
      tck_cycle(i == 7, pat[i], b);
      got[i] = b;
    end
    tck_cycle(1'b1, 1'b0, b);
    tck_cycle(1'b0, 1'b0, b);
  endtask

  // SPI mode 0 frame, first 32 SDO bits returned
  task automatic spi_xfer(input logic [55:0] tx, input int nbits, output logic [31:0] rx);
    logic b;
    rx = '0;
    @(posedge clk) pads[3] <= 1'b0;
    for (int i = 0; i < nbits; i++) begin
      @(posedge clk) pads[1] <= tx[55-i];
      repeat (7) @(posedge clk);
      @(negedge clk) b = dps;
      if (i < 32) rx[31-i] = b;
      @(posedge clk) pads[0] <= 1'b1;
      repeat (7) @(posedge clk);
      @(posedge clk) pads[0] <= 1'b0;
    end
    repeat (4) @(posedge clk);
    pads[3] <= 1'b1;
    pads[1] <= 1'b0;
    repeat (16) @(posedge clk);
  endtask

  initial begin
    entry_t      e;
    logic [31:0] rx;
    logic [7:0]  got;
    clk    = 1'b0;
    arst_n = 1'b0;
    pads   = 8'b0011_1000;  // CSB/TMS, TRST_N, SRST_N high
    cycles = 0;
    limit  = 0;
    seed   = 32'hcee8_f30b;
    for (int i = 0; i < 4; i++) words[i] = $random(seed);

    add_entry(K_RST, 0, 0, 32'h2, 0);
    add_entry(K_STRAP, 0, 0, 0, 32'h2);
    add_entry(K_JID, 0, 0, 0, 32'h1a5e_c0d1);
    add_entry(K_JBYP, 0, 0, 32'hb5, {24'h0, 8'hb5 << 1});  // One TCK delay
    add_entry(K_RST, 0, 0, 32'h1, 0);
    add_entry(K_STRAP, 0, 0, 0, 32'h1);
    add_entry(K_SPI, OP_WRITE, 16'h0001, words[0], 0);
    add_entry(K_SPI, OP_WRITE, 16'h0002, words[1], 0);
    add_entry(K_SPI, OP_WRITE, 16'h0047, words[2], 0);  // Aliases 0x0007
    add_entry(K_SPI, OP_WRITE, 16'h0010, words[3], 0);
    add_entry(K_SPI, OP_READ, 16'h0001, 0, 0);
    add_entry(K_SPICHK, OP_READ, 16'h0002, 0, words[0]);
    add_entry(K_SPICHK, OP_READ, 16'h0007, 0, words[1]);
    add_entry(K_SPICHK, OP_READ, 16'h0010, 0, words[2]);
    add_entry(K_SPICHK, 8'h00, 0, 0, words[3]);
    add_entry(K_SPI, OP_WRITE, 16'h003f, 32'h4354, 0);
    add_entry(K_STAT, 0, 0, 0, 32'h4354);
    add_entry(K_SPI, OP_WRITE, 16'h003f, 32'h900d, 0);
    add_entry(K_STAT, 0, 0, 0, 32'h900d);
    add_entry(K_SPI, OP_WRITE, 16'h003f, 32'h1234, 0);  // Undefined code
    add_entry(K_STAT, 0, 0, 0, 32'h900d);
    add_entry(K_SPI, 8'h55, 16'h003f, 32'hbaad, 0);
    add_entry(K_STAT, 0, 0, 0, 32'h900d);
    add_entry(K_SPI, 8'h55, 16'h0001, 32'hdead_beef, 0);
    add_entry(K_SPI, OP_READ, 16'h0001, 0, 0);
    add_entry(K_SPICHK, 8'h00, 0, 0, words[0]);
    add_entry(K_SHORT, OP_WRITE, 16'h0002, 32'h0, 0);  // Cut after 20 bits
    add_entry(K_SPI, OP_READ, 16'h0002, 0, 0);
    add_entry(K_SPICHK, OP_READ, 16'h0010, 0, words[1]);
    add_entry(K_SPICHK, 8'h00, 0, 0, words[3]);
    add_entry(K_PINS, 0, 0, 32'h2, 0);  // Straps flipped after the latch
    add_entry(K_STRAP, 0, 0, 0, 32'h1);
    add_entry(K_SPI, OP_WRITE, 16'h0003, 32'h5a5a_0f0f, 0);
    add_entry(K_SPI, OP_READ, 16'h0003, 0, 0);
    add_entry(K_SPICHK, 8'h00, 0, 0, 32'h5a5a_0f0f);
    add_entry(K_PINS, 0, 0, 32'h1, 0);
    add_entry(K_RST, 0, 0, 32'h0, 0);  // Bootstrap low blocks writes
    add_entry(K_STRAP, 0, 0, 0, 32'h0);
    add_entry(K_SPI, OP_WRITE, 16'h0001, 32'hffff_0000, 0);
    add_entry(K_SPI, OP_WRITE, 16'h003f, 32'hbaad, 0);
    add_entry(K_STAT, 0, 0, 0, 32'h0);
    add_entry(K_RST, 0, 0, 32'h1, 0);
    add_entry(K_SPI, OP_READ, 16'h0001, 0, 0);
    add_entry(K_SPICHK, 8'h00, 0, 0, words[0]);
    limit = table_q.size() * 1200;

    foreach (table_q[n]) begin
      e = table_q[n];
      case (e.kind)
        K_RST: apply_reset(e.data[1:0]);
        K_JID: begin
          jtag_read_idcode(rx);
          assert (rx == e.exp)
            else stop_on_mismatch($sformatf("IDCODE %h, expected %h", rx, e.exp));
        end
        K_JBYP: begin
          jtag_bypass(e.data[7:0], got);
          assert (got == e.exp[7:0])
            else stop_on_mismatch($sformatf("BYPASS %h, expected %h", got, e.exp[7:0]));
        end
        K_SPI: spi_xfer({e.op, e.addr, e.data}, 56, rx);
        K_SPICHK: begin
          spi_xfer({e.op, e.addr, e.data}, 56, rx);
          assert (rx == e.exp)
            else stop_on_mismatch($sformatf("entry %0d SDO %h, expected %h", n, rx, e.exp));
        end
        K_SHORT: spi_xfer({e.op, e.addr, e.data}, 20, rx);
        K_STAT: begin
          assert (status == e.exp[15:0])
            else stop_on_mismatch($sformatf("status %h, expected %h", status, e.exp[15:0]));
        end
        K_STRAP: begin
          assert (strap == e.exp[1:0])
            else stop_on_mismatch($sformatf("strap %b, expected %b", strap, e.exp[1:0]));
        end
        K_PINS: begin
          @(posedge clk);
          pads[6] <= e.data[1];
          pads[7] <= e.data[0];
          repeat (16) @(posedge clk);
        end
        default: stop_on_mismatch("unknown table entry kind");
      endcase
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: sim/dbg_chip_assertions.sv
`timescale 1ns/1ps
// Credit handshake and strap latch checks, bound into the DUT
// Unused ports are tied off at the bind site
module dbg_chip_assertions import dbg_pkg::*; (
  input logic   clk_i,
  input logic   arst_n_i,
  input logic   req_valid_i,
  input logic   credit_ret_i,
  input strap_t strap_i
);

  logic [CREDIT_W-1:0] in_flight_q;  // Requests still waiting for their credit
  logic [1:0]          settle_q;     // Cycles since reset release, saturating

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_flight_q <= '0;
      settle_q    <= '0;
    end else begin
      in_flight_q <= in_flight_q + CREDIT_W'(req_valid_i) - CREDIT_W'(credit_ret_i);
      if (settle_q != 2'(SYNC_STAGES + 1)) settle_q <= settle_q + 1'b1;
    end
  end

  // Requests only while a credit is held
  a_req_needs_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |-> in_flight_q < CREDIT_W'(SRAM_CREDITS))
    else $error("req_valid raised with zero credits");

  a_credit_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |=> credit_ret_i)
    else $error("no credit return one cycle after req_valid");

  a_credit_has_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_ret_i |-> $past(req_valid_i))
    else $error("credit returned without a request");

  // Straps are latched SYNC_STAGES+1 cycles after reset release
  a_strap_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    settle_q == 2'(SYNC_STAGES + 1) |=> $stable(strap_i))
    else $error("strap changed after latching");

endmodule

bind spi_cmd_rx dbg_chip_assertions i_spi_checks (
  .clk_i(clk_i), .arst_n_i(arst_n_i), .req_valid_i(req_valid_o),
  .credit_ret_i(rsp_i.credit), .strap_i(strap_i)
);

bind strap_sampler dbg_chip_assertions i_strap_checks (
  .clk_i(clk_i), .arst_n_i(arst_n_i), .req_valid_i(1'b0),
  .credit_ret_i(1'b0), .strap_i(strap_o)
);

// File: logic/dbg_chip_top.sv
`timescale 1ns/1ps
// Pad level debug subsystem, JTAG or SPI on shared pads chosen by strap
// SCK and TCK must run at no more than clk_i/8
// SRST_N strap resets the SPI receiver and the status register, not the memory
module dbg_chip_top import dbg_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic [7:0]   io_dps_i,
  output logic         dps_o,
  output strap_t       strap_o,
  output test_status_e test_status_o
);

  logic     sys_rst_n;
  logic     tck, tms, tdi, trst_n, tdo;
  logic     sck, csb, sdi, sdo;
  logic     req_valid;
  mem_req_t req;
  mem_rsp_t rsp;

  strap_sampler u_strap_sampler (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .srst_n_i     (io_dps_i[5]),
    .jtag_spi_n_i (io_dps_i[6]),
    .bootstrap_i  (io_dps_i[7]),
    .strap_o      (strap_o),
    .sys_rst_n_o  (sys_rst_n)
  );

  dps_pinmux u_dps_pinmux (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .io_dps_i (io_dps_i),
    .strap_i  (strap_o),
    .tck_o    (tck),
    .tms_o    (tms),
    .tdi_o    (tdi),
    .trst_n_o (trst_n),
    .sck_o    (sck),
    .csb_o    (csb),
    .sdi_o    (sdi),
    .tdo_i    (tdo),
    .sdo_i    (sdo),
    .dps_o    (dps_o)
  );

  jtag_idcode_tap u_jtag_tap (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .tck_i    (tck),
    .tms_i    (tms),
    .tdi_i    (tdi),
    .trst_n_i (trst_n),
    .tdo_o    (tdo)
  );

  spi_cmd_rx u_spi_cmd_rx (
    .clk_i       (clk_i),
    .arst_n_i    (sys_rst_n),  // Software reset strap domain
    .sck_i       (sck),
    .csb_i       (csb),
    .sdi_i       (sdi),
    .sdo_o       (sdo),
    .strap_i     (strap_o),
    .req_valid_o (req_valid),
    .req_o       (req),
    .rsp_i       (rsp)
  );

  sim_sram u_sim_sram (
    .clk_i         (clk_i),
    .arst_n_i      (sys_rst_n),
    .req_valid_i   (req_valid),
    .req_i         (req),
    .rsp_o         (rsp),
    .test_status_o (test_status_o)
  );

endmodule

// File: sim_sram/sim_sram.sv
`timescale 1ns/1ps
// Simulation memory, only the low address bits index it so addresses alias
// Answers every request one cycle later with a credit, reads carry the word
// STATUS_ADDR is also stored as a normal word besides updating test_status_o
module sim_sram import dbg_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         req_valid_i,
  input  mem_req_t     req_i,
  output mem_rsp_t     rsp_o,
  output test_status_e test_status_o
);

  logic [31:0]        mem_q [SRAM_WORDS];
  logic [SRAM_AW-1:0] idx;
  logic               credit_q;
  logic [31:0]        rdata_q;
  test_status_e       status_q;
  logic               status_wr;

  assign idx       = req_i.addr[SRAM_AW-1:0];
  assign status_wr = req_valid_i && req_i.write && (req_i.addr == STATUS_ADDR);

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      if (req_i.write) begin
        mem_q[idx] <= req_i.data;
        rdata_q    <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  // Credit goes back exactly one cycle after each request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= req_valid_i;
    end
  end

  // Test status register, undefined codes are ignored
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_q <= ST_IDLE;
    end else if (status_wr) begin
      case (req_i.data[15:0])
        ST_IDLE,
        ST_IN_TEST,
        ST_PASSED,
        ST_FAILED: status_q <= test_status_e'(req_i.data[15:0]);
        default: ;
      endcase
    end
  end

  assign rsp_o         = '{credit: credit_q, rdata: rdata_q};
  assign test_status_o = status_q;

endmodule

// File: spi_device/spi_cmd_rx.sv
`timescale 1ns/1ps
// SPI mode 0, SCK below clk_i/8; each frame is framed by its own CSB low period
// Read data is captured assuming the SRAM answers one cycle after req_valid_o
// One pending request, a frame completing while it waits is dropped
module spi_cmd_rx import dbg_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     sck_i,
  input  logic     csb_i,
  input  logic     sdi_i,
  output logic     sdo_o,
  input  strap_t   strap_i,
  output logic     req_valid_o,
  output mem_req_t req_o,
  input  mem_rsp_t rsp_i
);

  logic                  sck_q, csb_q;
  logic                  sck_rise, sck_fall, csb_fall, csb_rise;
  logic [BIT_CNT_W-1:0]  bit_cnt_q;
  logic [FRAME_BITS-2:0] shift_q;
  logic [FRAME_BITS-1:0] frame_d;
  logic                  frame_done;
  spi_op_e               op;
  logic                  op_valid;
  logic                  accept;
  logic                  pend_q;
  mem_req_t              pend_req_q;
  logic [CREDIT_W-1:0]   credit_q;
  logic                  rd_wait_q;
  logic [31:0]           rd_data_q;
  logic [31:0]           sdo_q;

  assign sck_rise = sck_i & ~sck_q & ~csb_i;
  assign sck_fall = ~sck_i & sck_q & ~csb_i;
  assign csb_fall = ~csb_i & csb_q;
  assign csb_rise = csb_i & ~csb_q;

  assign frame_d    = {shift_q, sdi_i};  // Frame including the bit sampled now
  assign frame_done = sck_rise && (bit_cnt_q == BIT_CNT_W'(FRAME_BITS - 1));
  assign op         = spi_op_e'(frame_d[FRAME_BITS-1 -: 8]);
  assign op_valid   = strap_i.bootstrap && (op == OP_WRITE || op == OP_READ);

  assign req_valid_o = pend_q && (credit_q != '0);
  assign req_o       = pend_req_q;
  assign accept      = frame_done && op_valid && (!pend_q || req_valid_o);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_q     <= 1'b0;
      csb_q     <= 1'b1;
      bit_cnt_q <= '0;
      pend_q    <= 1'b0;
      credit_q  <= CREDIT_W'(SRAM_CREDITS);
      rd_wait_q <= 1'b0;
      rd_data_q <= '0;
      sdo_q     <= '0;
    end else begin
      sck_q <= sck_i;
      csb_q <= csb_i;

      if (csb_i) begin
        bit_cnt_q <= '0;  // Also aborts a short frame
      end else if (sck_rise) begin
        bit_cnt_q <= frame_done ? '0 : bit_cnt_q + 1'b1;
      end

      if (accept) pend_q <= 1'b1;
      else if (req_valid_o) pend_q <= 1'b0;

      credit_q  <= credit_q - CREDIT_W'(req_valid_o) + CREDIT_W'(rsp_i.credit);
      rd_wait_q <= req_valid_o & ~pend_req_q.write;
      if (rsp_i.credit && rd_wait_q) rd_data_q <= rsp_i.rdata;

      // Last read word goes out first, zeros follow
      if (csb_fall) sdo_q <= rd_data_q;
      else if (csb_rise) sdo_q <= '0;
      else if (sck_fall) sdo_q <= {sdo_q[30:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i) begin
    if (sck_rise) shift_q <= frame_d[FRAME_BITS-2:0];
    if (accept) begin
      pend_req_q.write <= (op == OP_WRITE);
      pend_req_q.addr  <= frame_d[FRAME_BITS-9 -: 16];
      pend_req_q.data  <= frame_d[31:0];
    end
  end

  assign sdo_o = sdo_q[31];

endmodule

// File: logic/jtag_idcode_tap.sv
`timescale 1ns/1ps
// TAP stepped on synchronized TCK edges, so TCK must stay below clk_i/8
// Only IDCODE is decoded, every other instruction acts as BYPASS
// TRST_N is sampled like a synchronous reset of the TAP
module jtag_idcode_tap import dbg_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic tck_i,
  input  logic tms_i,
  input  logic tdi_i,
  input  logic trst_n_i,
  output logic tdo_o
);

  tap_state_e        state_q, state_d;
  logic              tck_q;
  logic              tck_rise, tck_fall;
  logic [IR_LEN-1:0] ir_q;
  logic [IR_LEN-1:0] ir_shift_q;
  logic [31:0]       dr_q;
  logic              idcode_sel;

  assign tck_rise   = tck_i & ~tck_q;
  assign tck_fall   = ~tck_i & tck_q;
  assign idcode_sel = (ir_q == IR_IDCODE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      TAP_RESET:    state_d = tms_i ? TAP_RESET    : TAP_IDLE;
      TAP_IDLE:     state_d = tms_i ? TAP_SEL_DR   : TAP_IDLE;
      TAP_SEL_DR:   state_d = tms_i ? TAP_SEL_IR   : TAP_CAP_DR;
      TAP_CAP_DR:   state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_SHIFT_DR: state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_EXIT1_DR: state_d = tms_i ? TAP_UPD_DR   : TAP_PAUSE_DR;
      TAP_PAUSE_DR: state_d = tms_i ? TAP_EXIT2_DR : TAP_PAUSE_DR;
      TAP_EXIT2_DR: state_d = tms_i ? TAP_UPD_DR   : TAP_SHIFT_DR;
      TAP_UPD_DR:   state_d = tms_i ? TAP_SEL_DR   : TAP_IDLE;
      TAP_SEL_IR:   state_d = tms_i ? TAP_RESET    : TAP_CAP_IR;
      TAP_CAP_IR:   state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_SHIFT_IR: state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_EXIT1_IR: state_d = tms_i ? TAP_UPD_IR   : TAP_PAUSE_IR;
      TAP_PAUSE_IR: state_d = tms_i ? TAP_EXIT2_IR : TAP_PAUSE_IR;
      TAP_EXIT2_IR: state_d = tms_i ? TAP_UPD_IR   : TAP_SHIFT_IR;
      TAP_UPD_IR:   state_d = tms_i ? TAP_SEL_DR   : TAP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tck_q   <= 1'b0;
      state_q <= TAP_RESET;
      ir_q    <= IR_IDCODE;
      tdo_o   <= 1'b0;
    end else begin
      tck_q <= tck_i;
      if (!trst_n_i) begin
        state_q <= TAP_RESET;
        ir_q    <= IR_IDCODE;
        tdo_o   <= 1'b0;
      end else begin
        if (tck_rise) state_q <= state_d;
        if (state_q == TAP_RESET) begin
          ir_q <= IR_IDCODE;
        end else if (tck_rise && state_q == TAP_UPD_IR) begin
          ir_q <= ir_shift_q;
        end
        // TDO follows the register LSB on the falling edge
        if (tck_fall) begin
          if (state_q == TAP_SHIFT_DR) tdo_o <= dr_q[0];
          else if (state_q == TAP_SHIFT_IR) tdo_o <= ir_shift_q[0];
          else tdo_o <= 1'b0;
        end
      end
    end
  end

  // Shift registers, LSB first toward TDO
  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      case (state_q)
        TAP_CAP_DR: dr_q <= idcode_sel ? IDCODE_VALUE : 32'h0;
        TAP_SHIFT_DR: begin
          if (idcode_sel) dr_q <= {tdi_i, dr_q[31:1]};
          else dr_q[0] <= tdi_i;  // 1-bit bypass
        end
        TAP_CAP_IR:   ir_shift_q <= IR_CAPTURE;
        TAP_SHIFT_IR: ir_shift_q <= {tdi_i, ir_shift_q[IR_LEN-1:1]};
        default: ;
      endcase
    end
  end

endmodule

// File: pinmux/dps_pinmux.sv
`timescale 1ns/1ps
// Pads 0, 1, 3 and 4 are synchronized here, pad 2 is the shared serial output
// The block not picked by the latched jtag_sel sees TCK 0, TMS 1, CSB 1
// Straps on pads 5 to 7 are handled by the strap sampler
module dps_pinmux import dbg_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic [7:0] io_dps_i,
  input  strap_t     strap_i,
  output logic       tck_o,
  output logic       tms_o,
  output logic       tdi_o,
  output logic       trst_n_o,
  output logic       sck_o,
  output logic       csb_o,
  output logic       sdi_o,
  input  logic       tdo_i,
  input  logic       sdo_i,
  output logic       dps_o
);

  logic [SYNC_STAGES-1:0][3:0] sync_q;  // {trst_n, tms/csb, tdi/sdi, tck/sck}
  logic [3:0] pins_s;
  logic       jtag_sel;
  logic       dps_q;

  assign jtag_sel = strap_i.jtag_sel;
  assign pins_s   = sync_q[SYNC_STAGES-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= {SYNC_STAGES{4'b0100}};  // Idle levels, CSB and TMS high
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0],
                 {io_dps_i[4], io_dps_i[3], io_dps_i[1], io_dps_i[0]}};
    end
  end

  // JTAG side
  assign tck_o    = jtag_sel & pins_s[0];
  assign tdi_o    = jtag_sel & pins_s[1];
  assign tms_o    = ~jtag_sel | pins_s[2];
  assign trst_n_o = jtag_sel & pins_s[3];  // TAP held in reset while SPI owns the pads

  // SPI side
  assign sck_o = ~jtag_sel & pins_s[0];
  assign sdi_o = ~jtag_sel & pins_s[1];
  assign csb_o = jtag_sel | pins_s[2];

  // Pad output lags the selected source by one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dps_q <= 1'b0;
    end else begin
      dps_q <= jtag_sel ? tdo_i : sdo_i;
    end
  end

  assign dps_o = dps_q;

endmodule

// File: logic/strap_sampler.sv
`timescale 1ns/1ps
// Straps latch once, SYNC_STAGES+1 cycles after arst_n_i release
// Only a new reset takes a new sample, pin changes after that are ignored
// sys_rst_n_o is the synchronized SRST_N pin and is never latched
module strap_sampler import dbg_pkg::*; (
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  logic   srst_n_i,
  input  logic   jtag_spi_n_i,
  input  logic   bootstrap_i,
  output strap_t strap_o,
  output logic   sys_rst_n_o
);

  logic [SYNC_STAGES-1:0][2:0] sync_q;  // {srst_n, jtag_spi_n, bootstrap}
  logic [2:0] pins_s;
  logic [1:0] wait_cnt_q;
  logic       latched_q;
  strap_t     strap_q;

  assign pins_s = sync_q[SYNC_STAGES-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], {srst_n_i, jtag_spi_n_i, bootstrap_i}};
    end
  end

  // Wait for the synchronizer to fill, then sample exactly once
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_cnt_q <= '0;
      latched_q  <= 1'b0;
      strap_q    <= '0;
    end else if (!latched_q) begin
      if (wait_cnt_q == 2'(SYNC_STAGES)) begin
        strap_q.jtag_sel  <= pins_s[1];
        strap_q.bootstrap <= pins_s[0];
        latched_q         <= 1'b1;
      end else begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  assign strap_o     = strap_q;
  assign sys_rst_n_o = pins_s[2];  // Low while SRST_N strap is low

endmodule

// File: common/dbg_pkg.sv
// Shared constants and types for the debug and bootstrap subsystem
// Frame format, memory depth and credit count are fixed here for all blocks
package dbg_pkg;

  // JTAG
  localparam logic [31:0] IDCODE_VALUE = 32'h1a5e_c0d1;
  localparam int unsigned IR_LEN       = 5;
  localparam logic [IR_LEN-1:0] IR_IDCODE  = 5'b00001;
  localparam logic [IR_LEN-1:0] IR_CAPTURE = 5'b00001;  // Fixed IR capture pattern

  // SPI frame: opcode, 2 address bytes, 4 data bytes, MSB first
  localparam int unsigned FRAME_BYTES = 7;
  localparam int unsigned FRAME_BITS  = FRAME_BYTES * 8;
  localparam int unsigned BIT_CNT_W   = $clog2(FRAME_BITS);

  // Memory and request path
  localparam int unsigned SRAM_WORDS   = 64;
  localparam int unsigned SRAM_AW      = $clog2(SRAM_WORDS);
  localparam int unsigned SRAM_CREDITS = 2;
  localparam int unsigned CREDIT_W     = $clog2(SRAM_CREDITS + 1);
  localparam logic [15:0] STATUS_ADDR  = 16'h003f;

  localparam int unsigned SYNC_STAGES = 2;  // Pin synchronizer depth

  typedef enum logic [7:0] {
    OP_WRITE = 8'h02,
    OP_READ  = 8'h03
  } spi_op_e;

  typedef enum logic [3:0] {
    TAP_RESET,
    TAP_IDLE,
    TAP_SEL_DR,
    TAP_CAP_DR,
    TAP_SHIFT_DR,
    TAP_EXIT1_DR,
    TAP_PAUSE_DR,
    TAP_EXIT2_DR,
    TAP_UPD_DR,
    TAP_SEL_IR,
    TAP_CAP_IR,
    TAP_SHIFT_IR,
    TAP_EXIT1_IR,
    TAP_PAUSE_IR,
    TAP_EXIT2_IR,
    TAP_UPD_IR
  } tap_state_e;

  typedef enum logic [15:0] {
    ST_IDLE    = 16'h0000,
    ST_IN_TEST = 16'h4354,
    ST_PASSED  = 16'h900d,
    ST_FAILED  = 16'hbaad
  } test_status_e;

  typedef struct packed {
    logic jtag_sel;
    logic bootstrap;
  } strap_t;

  typedef struct packed {
    logic        write;
    logic [15:0] addr;
    logic [31:0] data;
  } mem_req_t;

  typedef struct packed {
    logic        credit;  // One cycle per returned credit
    logic [31:0] rdata;
  } mem_rsp_t;

endpackage
